// File: dv/tb_biquad_cascade.sv
`timescale 1ns/1ns

module tb_biquad_cascade
    import biquad_pkg::*;
    import coef_bus_pkg::*;
();

    // upper bound on the length of all directed tests
    localparam int TEST_CYCLES    = 2000;
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

    logic                     aclk;
    logic                     reset_i;
    logic                     filter_clear_i;
    sample_vec_t              dat_i;
    sample_vec_t              dat_o;
    logic                     bus_req_i;
    logic                     bus_we_i;
    logic [BUS_ADDR_BITS-1:0] bus_addr_i;
    logic [BUS_DATA_BITS-1:0] bus_wdata_i;
    logic [BUS_DATA_BITS-1:0] bus_rdata_o;
    logic                     bus_ack_o;

    // reference model state with index 0 for stage a
    coef_set_t m_coef [2];
    sample_t   m_x1 [2];
    sample_t   m_x2 [2];
    sample_t   m_y1 [2];
    sample_t   m_y2 [2];

    // handshake monitor
    logic ack_prev;
    int   ack_rises;
    int   ack_falls;
    int   cycle_count;

    tb_clock_gen u_clock_gen (
        .aclk_o  (aclk),
        .reset_o (reset_i)
    );

    biquad_cascade uut (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .filter_clear_i (filter_clear_i),
        .dat_i          (dat_i),
        .dat_o          (dat_o),
        .bus_req_i      (bus_req_i),
        .bus_we_i       (bus_we_i),
        .bus_addr_i     (bus_addr_i),
        .bus_wdata_i    (bus_wdata_i),
        .bus_rdata_o    (bus_rdata_o),
        .bus_ack_o      (bus_ack_o)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_sample_vec(input string name, input sample_vec_t exp,
                                    input sample_vec_t act);
        if (act !== exp) begin
            abort_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_coef(input string name, input coef_t exp, input coef_t act);
        if (act !== exp) begin
            abort_run($sformatf("error: %s expected %0d actual %0d", name, exp, act));
        end
    endtask

    task automatic check_rdata(input string name, input logic [BUS_DATA_BITS-1:0] exp,
                               input logic [BUS_DATA_BITS-1:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // stage select in the msb above the register address
    function automatic logic [BUS_ADDR_BITS-1:0] reg_addr(input int stage, input int r);
        return {stage[0], r[REG_ADDR_BITS-1:0]};
    endfunction

    // one four-phase transfer on the top-level bus
    task automatic bus_transfer(input logic we, input logic [BUS_ADDR_BITS-1:0] addr,
                                input logic [BUS_DATA_BITS-1:0] wdata,
                                output logic [BUS_DATA_BITS-1:0] rdata);
        @(posedge aclk);
        if (bus_ack_o) begin
            abort_run("bus_ack_o still high when a new transfer starts");
        end
        bus_req_i   <= 1'b1;
        bus_we_i    <= we;
        bus_addr_i  <= addr;
        bus_wdata_i <= wdata;
        do @(negedge aclk); while (!bus_ack_o);
        rdata = bus_rdata_o;
        @(posedge aclk);
        bus_req_i <= 1'b0;
        do @(negedge aclk); while (bus_ack_o);
    endtask

    task automatic bus_write(input logic [BUS_ADDR_BITS-1:0] addr,
                             input logic [BUS_DATA_BITS-1:0] wdata);
        logic [BUS_DATA_BITS-1:0] unused;
        bus_transfer(1'b1, addr, wdata, unused);
    endtask

    task automatic bus_read(input logic [BUS_ADDR_BITS-1:0] addr,
                            output logic [BUS_DATA_BITS-1:0] rdata);
        bus_transfer(1'b0, addr, '0, rdata);
    endtask

    // five shadow writes sign-extended to bus width
    task automatic write_shadow(input int stage, input coef_set_t c);
        bus_write(reg_addr(stage, REG_B0), BUS_DATA_BITS'(c.b0));
        bus_write(reg_addr(stage, REG_B1), BUS_DATA_BITS'(c.b1));
        bus_write(reg_addr(stage, REG_B2), BUS_DATA_BITS'(c.b2));
        bus_write(reg_addr(stage, REG_A1), BUS_DATA_BITS'(c.a1));
        bus_write(reg_addr(stage, REG_A2), BUS_DATA_BITS'(c.a2));
    endtask

    function automatic int rand_signed(input int limit);
        return int'($urandom_range(2 * limit, 0)) - limit;
    endfunction

    // |b| below 0.75 with |a1| below 1.0 and |a2| below 0.5
    function automatic coef_set_t random_coef_set();
        coef_set_t c;
        c.b0 = coef_t'(rand_signed(12287));
        c.b1 = coef_t'(rand_signed(12287));
        c.b2 = coef_t'(rand_signed(12287));
        c.a1 = coef_t'(rand_signed(16383));
        c.a2 = coef_t'(rand_signed(8191));
        return c;
    endfunction

    // full_scale mixes in rail values to force saturation
    function automatic sample_vec_t random_vec(input bit full_scale);
        sample_vec_t v;
        for (int i = 0; i < NSAMP; i++) begin
            if (full_scale && $urandom_range(3, 0) == 0) begin
                v[i] = ($urandom_range(1, 0) == 1) ? SAMPLE_MAX : SAMPLE_MIN;
            end else begin
                v[i] = sample_t'($urandom);
            end
        end
        return v;
    endfunction

    function automatic void model_clear();
        for (int s = 0; s < 2; s++) begin
            m_x1[s] = '0;
            m_x2[s] = '0;
            m_y1[s] = '0;
            m_y2[s] = '0;
        end
    endfunction

    // direct-form I per sample with floor shift then saturation
    function automatic sample_vec_t model_stage(input int s, input sample_vec_t x);
        sample_vec_t y;
        longint      acc;
        longint      q;
        for (int i = 0; i < NSAMP; i++) begin
            acc = longint'(m_coef[s].b0) * longint'(x[i])
                + longint'(m_coef[s].b1) * longint'(m_x1[s])
                + longint'(m_coef[s].b2) * longint'(m_x2[s])
                - longint'(m_coef[s].a1) * longint'(m_y1[s])
                - longint'(m_coef[s].a2) * longint'(m_y2[s]);
            q = acc >>> COEF_FRAC;
            if (q > SAMPLE_MAX) q = SAMPLE_MAX;
            if (q < SAMPLE_MIN) q = SAMPLE_MIN;
            y[i]    = sample_t'(q);
            m_x2[s] = m_x1[s];
            m_x1[s] = x[i];
            m_y2[s] = m_y1[s];
            m_y1[s] = y[i];
        end
        return y;
    endfunction

    // hold input at zero across a clear
    // model restarts from zero history
    task automatic pulse_clear();
        @(posedge aclk);
        filter_clear_i <= 1'b1;
        dat_i          <= '0;
        repeat (2) @(posedge aclk);
        filter_clear_i <= 1'b0;
        model_clear();
    endtask

    // drive one vector per clock and check each two clocks later
    // two zero vectors flush the pipe at the end
    task automatic run_stream(input string name, input int count, input bit full_scale);
        sample_vec_t v;
        sample_vec_t exp_q [$];
        for (int j = 0; j < count + 2; j++) begin
            @(posedge aclk);
            v = (j < count) ? random_vec(full_scale) : '0;
            dat_i <= v;
            exp_q.push_back(model_stage(1, model_stage(0, v)));
            @(negedge aclk);
            if (j >= 2) check_sample_vec(name, exp_q.pop_front(), dat_o);
        end
    endtask

    task automatic register_readback();
        logic [BUS_DATA_BITS-1:0] w [5];
        logic [BUS_DATA_BITS-1:0] rd;
        logic [BUS_DATA_BITS-1:0] exp_rd;
        coef_t                    c;
        for (int s = 0; s < 2; s++) begin
            for (int r = 0; r < 5; r++) begin
                w[r] = $urandom;
                bus_write(reg_addr(s, r), w[r]);
            end
            // unmapped writes are dropped
            bus_write(reg_addr(s, 6), $urandom);
            bus_write(reg_addr(s, 7), $urandom);
            for (int r = 0; r < 5; r++) begin
                bus_read(reg_addr(s, r), rd);
                c = coef_t'(w[r][COEF_BITS-1:0]);
                // upper bus bits repeat the top bit of the stored coefficient
                exp_rd = $signed(w[r] << (BUS_DATA_BITS - COEF_BITS))
                         >>> (BUS_DATA_BITS - COEF_BITS);
                check_coef("register_readback", c, coef_t'(rd[COEF_BITS-1:0]));
                check_rdata("register_readback", exp_rd, rd);
            end
            // commit and unmapped 6 and 7 read zero
            for (int r = 5; r < 8; r++) begin
                bus_read(reg_addr(s, r), rd);
                check_rdata("register_readback", '0, rd);
            end
        end
    endtask

    task automatic shadow_commit();
        coef_set_t new_a;
        coef_set_t new_b;
        new_a = random_coef_set();
        new_b = random_coef_set();
        write_shadow(0, new_a);
        write_shadow(1, new_b);
        // model keeps pass-through since nothing is committed yet
        pulse_clear();
        run_stream("shadow_no_commit", 30, 1'b0);
        bus_write(reg_addr(1, REG_COMMIT), '0);
        m_coef[1] = new_b;
        pulse_clear();
        run_stream("commit_stage_b", 30, 1'b0);
    endtask

    task automatic random_filter();
        coef_set_t new_a;
        coef_set_t new_b;
        new_a = random_coef_set();
        new_b = random_coef_set();
        write_shadow(0, new_a);
        write_shadow(1, new_b);
        bus_write(reg_addr(0, REG_COMMIT), '0);
        bus_write(reg_addr(1, REG_COMMIT), '0);
        m_coef[0] = new_a;
        m_coef[1] = new_b;
        pulse_clear();
        run_stream("random_filter", 200, 1'b1);
    endtask

    task automatic history_clear();
        run_stream("pre_clear", 20, 1'b1);
        @(posedge aclk);
        filter_clear_i <= 1'b1;
        dat_i          <= random_vec(1'b1);
        // output pinned at zero while clear is high
        for (int k = 0; k < 4; k++) begin
            @(posedge aclk);
            dat_i <= random_vec(1'b1);
            @(negedge aclk);
            check_sample_vec("history_clear", '0, dat_o);
        end
        @(posedge aclk);
        filter_clear_i <= 1'b0;
        dat_i          <= '0;
        model_clear();
        run_stream("after_clear", 40, 1'b1);
    endtask

    task automatic handshake_order();
        int                       rises0;
        int                       falls0;
        logic [BUS_DATA_BITS-1:0] rd;
        rises0 = ack_rises;
        falls0 = ack_falls;
        for (int k = 0; k < 4; k++) begin
            bus_read(reg_addr(k % 2, k), rd);
        end
        bus_write(reg_addr(0, REG_B1), $urandom);
        // let the monitor see the last falling ack
        @(posedge aclk);
        if (ack_rises - rises0 != 5 || ack_falls - falls0 != 5) begin
            abort_run($sformatf("error: handshake_order expected 5 ack pulses actual %0d/%0d",
                                ack_rises - rises0, ack_falls - falls0));
        end
    endtask

    // ack edges against req level
    always @(negedge aclk) begin
        if (!reset_i) begin
            if (bus_ack_o && !ack_prev) begin
                if (!bus_req_i) abort_run("bus_ack_o rose while bus_req_i was low");
                ack_rises++;
            end
            if (!bus_ack_o && ack_prev) begin
                if (bus_req_i) abort_run("bus_ack_o fell while bus_req_i was high");
                ack_falls++;
            end
        end
        ack_prev = bus_ack_o;
    end

    always @(posedge aclk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, run exceeded %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        void'($urandom(32'he9a1_a1bf));
        filter_clear_i = 1'b0;
        dat_i          = '0;
        bus_req_i      = 1'b0;
        bus_we_i       = 1'b0;
        bus_addr_i     = '0;
        bus_wdata_i    = '0;
        ack_prev       = 1'b0;
        ack_rises      = 0;
        ack_falls      = 0;
        cycle_count    = 0;
        m_coef[0]      = COEF_SET_PASS;
        m_coef[1]      = COEF_SET_PASS;
        model_clear();
        do @(negedge aclk); while (reset_i);
        check_sample_vec("reset_state", '0, dat_o);

        run_stream("reset_passthrough", 40, 1'b1);
        register_readback();
        shadow_commit();
        random_filter();
        history_clear();
        handshake_order();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ns

// free-running aclk and power-on reset
module tb_clock_gen (
    output logic aclk_o,
    output logic reset_o
);

    // 8 ns period
    localparam int HALF_PERIOD = 4;

    initial begin
        aclk_o = 1'b0;
        forever #HALF_PERIOD aclk_o = ~aclk_o;
    end

    // reset held for four rising edges
    initial begin
        reset_o = 1'b1;
        repeat (4) @(posedge aclk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: list.f
logic/biquad_pkg.sv
logic/coef_bus_pkg.sv
logic/coef_bus_if.sv
logic/coef_bus_router.sv
logic/biquad_coef_regs.sv
logic/biquad_stage.sv
logic/biquad_cascade.sv
dv/tb_clock_gen.sv
dv/tb_biquad_cascade.sv

// File: logic/biquad_cascade.sv
`timescale 1ns/1ns

// two biquad stages in series, one register bus split on address msb
module biquad_cascade
    import biquad_pkg::*;
    import coef_bus_pkg::*;
(
    input  logic                     aclk,
    input  logic                     reset_i,
    // clears filter history of both stages
    input  logic                     filter_clear_i,
    input  sample_vec_t              dat_i,
    output sample_vec_t              dat_o,
    // coefficient register bus, four-phase
    input  logic                     bus_req_i,
    input  logic                     bus_we_i,
    input  logic [BUS_ADDR_BITS-1:0] bus_addr_i,
    input  logic [BUS_DATA_BITS-1:0] bus_wdata_i,
    output logic [BUS_DATA_BITS-1:0] bus_rdata_o,
    output logic                     bus_ack_o
);

    // per-stage register transfer
    coef_bus_if bus_a_if ();
    coef_bus_if bus_b_if ();

    // active coefficients of each stage
    coef_set_t   coef_a;
    coef_set_t   coef_b;
    // stage a output, stage b input
    sample_vec_t dat_mid;

    coef_bus_router u_router (
        .aclk        (aclk),
        .reset_i     (reset_i),
        .bus_req_i   (bus_req_i),
        .bus_we_i    (bus_we_i),
        .bus_addr_i  (bus_addr_i),
        .bus_wdata_i (bus_wdata_i),
        .bus_rdata_o (bus_rdata_o),
        .bus_ack_o   (bus_ack_o),
        .bus_a       (bus_a_if.master),
        .bus_b       (bus_b_if.master)
    );

    // address msb low
    biquad_coef_regs u_coef_a (
        .aclk    (aclk),
        .reset_i (reset_i),
        .bus     (bus_a_if.slave),
        .coef_o  (coef_a)
    );

    // address msb high
    biquad_coef_regs u_coef_b (
        .aclk    (aclk),
        .reset_i (reset_i),
        .bus     (bus_b_if.slave),
        .coef_o  (coef_b)
    );

    biquad_stage u_stage_a (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .filter_clear_i (filter_clear_i),
        .coef_i         (coef_a),
        .dat_i          (dat_i),
        .dat_o          (dat_mid)
    );

    biquad_stage u_stage_b (
        .aclk           (aclk),
        .reset_i        (reset_i),
        .filter_clear_i (filter_clear_i),
        .coef_i         (coef_b),
        .dat_i          (dat_mid),
        .dat_o          (dat_o)
    );

endmodule

// File: logic/biquad_coef_regs.sv
`timescale 1ns/1ns

module biquad_coef_regs
    import biquad_pkg::*;
    import coef_bus_pkg::*;
(
    input  logic      aclk,
    input  logic      reset_i,
    coef_bus_if.slave bus,
    // active set, feeds the stage
    output coef_set_t coef_o
);

    coef_set_t                shadow_q;
    coef_set_t                active_q;
    logic                     ack_q;
    logic [BUS_DATA_BITS-1:0] rdata_q;
    coef_reg_e                reg_sel;
    coef_t                    wr_coef;
    // first cycle of a transfer
    logic                     start;

    // sign-extend a coefficient to bus width
    function automatic logic [BUS_DATA_BITS-1:0] sign_extend(input coef_t c);
        return {{(BUS_DATA_BITS-COEF_BITS){c[COEF_BITS-1]}}, c};
    endfunction

    assign reg_sel = coef_reg_e'(bus.addr);
    // low bits of wdata only
    assign wr_coef = coef_t'(bus.wdata[COEF_BITS-1:0]);
    assign start   = bus.req & ~ack_q;

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;
    assign coef_o    = active_q;

    // ack follows req one cycle later, both edges
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            ack_q <= 1'b0;
        end else if (start) begin
            ack_q <= 1'b1;
        end else if (!bus.req && ack_q) begin
            ack_q <= 1'b0;
        end
    end

    // shadow writes and commit
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            shadow_q <= COEF_SET_PASS;
            active_q <= COEF_SET_PASS;
        end else if (start && bus.we) begin
            case (reg_sel)
                REG_B0:     shadow_q.b0 <= wr_coef;
                REG_B1:     shadow_q.b1 <= wr_coef;
                REG_B2:     shadow_q.b2 <= wr_coef;
                REG_A1:     shadow_q.a1 <= wr_coef;
                REG_A2:     shadow_q.a2 <= wr_coef;
                // whole set moves at once, same edge as ack
                REG_COMMIT: active_q <= shadow_q;
                // unmapped, write ignored
                default: ;
            endcase
        end
    end

    // readback of the shadow set
    always_ff @(posedge aclk) begin
        if (start) begin
            case (reg_sel)
                REG_B0:  rdata_q <= sign_extend(shadow_q.b0);
                REG_B1:  rdata_q <= sign_extend(shadow_q.b1);
                REG_B2:  rdata_q <= sign_extend(shadow_q.b2);
                REG_A1:  rdata_q <= sign_extend(shadow_q.a1);
                REG_A2:  rdata_q <= sign_extend(shadow_q.a2);
                // commit and unmapped read zero
                default: rdata_q <= '0;
            endcase
        end
    end

endmodule

// File: logic/biquad_pkg.sv
package biquad_pkg;

    // sample format, signed integer samples
    localparam int SAMPLE_BITS = 12;
    // samples carried on each clock
    localparam int NSAMP = 8;

    // coefficient format, signed Q3.14
    localparam int COEF_BITS = 18;
    localparam int COEF_FRAC = 14;

    // full-precision sum of five products
    // three guard bits cover the five-term sum
    localparam int ACC_BITS = COEF_BITS + SAMPLE_BITS + 3;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // element 0 is the oldest sample of the clock
    typedef sample_t [NSAMP-1:0] sample_vec_t;

    typedef logic signed [COEF_BITS-1:0] coef_t;

    // one stage's coefficients
    typedef struct packed {
        coef_t b0;
        coef_t b1;
        coef_t b2;
        coef_t a1;
        coef_t a2;
    } coef_set_t;

    // saturation limits of the output
    localparam sample_t SAMPLE_MAX = sample_t'(2047);
    localparam sample_t SAMPLE_MIN = sample_t'(-2048);

    // 1.0 in coefficient format
    localparam coef_t COEF_UNITY = coef_t'(1 << COEF_FRAC);

    // pass-through set, b0 = 1.0 and the rest zero
    localparam coef_set_t COEF_SET_PASS = '{COEF_UNITY, '0, '0, '0, '0};

endpackage

// File: logic/biquad_stage.sv
`timescale 1ns/1ns

module biquad_stage
    import biquad_pkg::*;
(
    input  logic        aclk,
    input  logic        reset_i,
    // zeroes history and output, coefficients untouched
    input  logic        filter_clear_i,
    input  coef_set_t   coef_i,
    input  sample_vec_t dat_i,
    output sample_vec_t dat_o
);

    // history from the previous clock
    // x1/y1 is n-1, x2/y2 is n-2
    sample_t     x1_q;
    sample_t     x2_q;
    sample_t     y1_q;
    sample_t     y2_q;
    // filtered vector, before the output register
    sample_vec_t y_comb;
    sample_vec_t out_q;

    assign dat_o = out_q;

    // direct-form I, sample by sample within the clock
    always_comb begin
        sample_t                     xm1;
        sample_t                     xm2;
        sample_t                     ym1;
        sample_t                     ym2;
        sample_t                     xn;
        sample_t                     yn;
        logic signed [ACC_BITS-1:0]  acc;
        logic signed [ACC_BITS-1:0]  shifted;

        // start from last clock's history
        xm1 = x1_q;
        xm2 = x2_q;
        ym1 = y1_q;
        ym2 = y2_q;
        for (int i = 0; i < NSAMP; i++) begin
            xn = dat_i[i];
            // full precision sum, all operands signed
            acc = coef_i.b0 * xn
                + coef_i.b1 * xm1
                + coef_i.b2 * xm2
                - coef_i.a1 * ym1
                - coef_i.a2 * ym2;
            // arithmetic shift, rounds toward minus infinity
            shifted = acc >>> COEF_FRAC;
            // saturate to sample range
            if (shifted > SAMPLE_MAX) begin
                yn = SAMPLE_MAX;
            end else if (shifted < SAMPLE_MIN) begin
                yn = SAMPLE_MIN;
            end else begin
                yn = sample_t'(shifted[SAMPLE_BITS-1:0]);
            end
            y_comb[i] = yn;
            // saturated value feeds the next sample
            xm2 = xm1;
            xm1 = xn;
            ym2 = ym1;
            ym1 = yn;
        end
    end

    // history and output register
    always_ff @(posedge aclk) begin
        if (reset_i || filter_clear_i) begin
            x1_q  <= '0;
            x2_q  <= '0;
            y1_q  <= '0;
            y2_q  <= '0;
            out_q <= '0;
        end else begin
            // newest two samples of the vector
            x1_q  <= dat_i[NSAMP-1];
            x2_q  <= dat_i[NSAMP-2];
            y1_q  <= y_comb[NSAMP-1];
            y2_q  <= y_comb[NSAMP-2];
            out_q <= y_comb;
        end
    end

endmodule

// File: logic/coef_bus_if.sv
`timescale 1ns/1ns

// one four-phase register transfer, router to coefficient bank
interface coef_bus_if
    import coef_bus_pkg::*;
();

    // request side, held stable while req is high
    logic                     req;
    logic                     we;
    logic [REG_ADDR_BITS-1:0] addr;
    logic [BUS_DATA_BITS-1:0] wdata;

    // response side, rdata valid while ack is high
    logic [BUS_DATA_BITS-1:0] rdata;
    logic                     ack;

    modport master (
        output req, we, addr, wdata,
        input  rdata, ack
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, ack
    );

endinterface

// File: logic/coef_bus_pkg.sv
package coef_bus_pkg;

    // top-level address, msb picks the stage
    localparam int BUS_ADDR_BITS = 4;
    localparam int STAGE_SEL_BIT = BUS_ADDR_BITS - 1;

    // register address inside one stage
    localparam int REG_ADDR_BITS = 3;

    localparam int BUS_DATA_BITS = 32;

    // register map of one coefficient bank
    // addresses 6 and 7 are unmapped
    typedef enum logic [REG_ADDR_BITS-1:0] {
        REG_B0     = 3'd0,
        REG_B1     = 3'd1,
        REG_B2     = 3'd2,
        REG_A1     = 3'd3,
        REG_A2     = 3'd4,
        REG_COMMIT = 3'd5
    } coef_reg_e;

    // router handshake states
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_FORWARD,
        BUS_HOLD,
        BUS_RELEASE
    } bus_state_e;

endpackage

// File: logic/coef_bus_router.sv
`timescale 1ns/1ns

module coef_bus_router
    import coef_bus_pkg::*;
(
    input  logic                     aclk,
    input  logic                     reset_i,
    // top-level four-phase slave
    input  logic                     bus_req_i,
    input  logic                     bus_we_i,
    input  logic [BUS_ADDR_BITS-1:0] bus_addr_i,
    input  logic [BUS_DATA_BITS-1:0] bus_wdata_i,
    output logic [BUS_DATA_BITS-1:0] bus_rdata_o,
    output logic                     bus_ack_o,
    // one master per stage
    coef_bus_if.master               bus_a,
    coef_bus_if.master               bus_b
);

    bus_state_e               state_q;
    // 0 picks stage a, 1 picks stage b
    logic                     sel_q;
    logic                     req_q;
    logic                     ack_q;
    logic                     we_q;
    logic [REG_ADDR_BITS-1:0] addr_q;
    logic [BUS_DATA_BITS-1:0] wdata_q;
    logic [BUS_DATA_BITS-1:0] rdata_q;
    // response of the selected stage
    logic                     slave_ack;
    logic [BUS_DATA_BITS-1:0] slave_rdata;

    assign slave_ack   = sel_q ? bus_b.ack : bus_a.ack;
    assign slave_rdata = sel_q ? bus_b.rdata : bus_a.rdata;

    // only the selected stage sees req
    assign bus_a.req   = req_q & ~sel_q;
    assign bus_b.req   = req_q & sel_q;
    // shared request payload
    assign bus_a.we    = we_q;
    assign bus_b.we    = we_q;
    assign bus_a.addr  = addr_q;
    assign bus_b.addr  = addr_q;
    assign bus_a.wdata = wdata_q;
    assign bus_b.wdata = wdata_q;

    assign bus_ack_o   = ack_q;
    assign bus_rdata_o = rdata_q;

    // handshake fsm
    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= BUS_IDLE;
            sel_q   <= 1'b0;
            req_q   <= 1'b0;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                BUS_IDLE: begin
                    // ack is low here, so a high req is a new transfer
                    if (bus_req_i) begin
                        sel_q   <= bus_addr_i[STAGE_SEL_BIT];
                        req_q   <= 1'b1;
                        state_q <= BUS_FORWARD;
                    end
                end
                BUS_FORWARD: begin
                    // wait for the stage to answer
                    if (slave_ack) begin
                        ack_q   <= 1'b1;
                        state_q <= BUS_HOLD;
                    end
                end
                BUS_HOLD: begin
                    // master releases first
                    if (!bus_req_i) begin
                        req_q   <= 1'b0;
                        state_q <= BUS_RELEASE;
                    end
                end
                BUS_RELEASE: begin
                    // stage drops ack, then we do
                    if (!slave_ack) begin
                        ack_q   <= 1'b0;
                        state_q <= BUS_IDLE;
                    end
                end
                default: state_q <= BUS_IDLE;
            endcase
        end
    end

    // request latch and read capture
    always_ff @(posedge aclk) begin
        if (state_q == BUS_IDLE && bus_req_i) begin
            we_q    <= bus_we_i;
            addr_q  <= bus_addr_i[REG_ADDR_BITS-1:0];
            wdata_q <= bus_wdata_i;
        end
        if (state_q == BUS_FORWARD && slave_ack) begin
            rdata_q <= slave_rdata;
        end
    end

endmodule
